// ==== include/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// bus and field widths
`define WORD_W    16 // bus word, offset and immediate
`define BYTE_W    8  // opcode and modrm
`define ADDR_W    20 // physical address

// segment:offset translation
`define SEG_SHIFT 4  // segment is paragraph aligned

// register file selector
`define SEL_W     4  // bit 3 marks a segment register

`endif

// ==== verilog/fetch_pkg.sv ====
`include "fetch_defines.svh"

package fetch_pkg;

  typedef enum logic [2:0] {
    OPCOD = 3'd0, // opcode byte
    MODRM = 3'd1, // modrm byte
    OFFSE = 3'd2, // displacement
    IMMED = 3'd3, // immediate
    EXECU = 3'd4  // execute, one cycle
  } fetch_state_t;

  typedef enum logic [4:0] {
    SEQ_NOP, SEQ_HLT, SEQ_PUSHF,
    SEQ_MOVRRB, SEQ_MOVRRW, SEQ_MOVRMB, SEQ_MOVRMW, SEQ_MOVMRB, SEQ_MOVMRW,
    SEQ_MOVMAB, SEQ_MOVMAW, SEQ_MOVAMB, SEQ_MOVAMW,
    SEQ_MOVIRB, SEQ_MOVIRW, SEQ_MOVIMB, SEQ_MOVIMW,
    SEQ_JMPI, SEQ_LJMPI, SEQ_JMPR, SEQ_JMPM, SEQ_LJMPM
  } seq_entry_t;

  typedef logic [`SEL_W-1:0] reg_sel_t; // bit 3 set -> segment reg
  typedef logic [1:0]        seg_sel_t;

  // register encodings seen by the address and move paths
  localparam reg_sel_t REG_AX   = 4'b0000; // accumulator, also "no reg"
  localparam reg_sel_t REG_BX   = 4'b0011;
  localparam reg_sel_t REG_BP   = 4'b0101;
  localparam reg_sel_t REG_SI   = 4'b0110;
  localparam reg_sel_t REG_DI   = 4'b0111;
  localparam reg_sel_t REG_NONE = 4'b1100; // no base / no index

  localparam seg_sel_t SEG_SS = 2'b10;
  localparam seg_sel_t SEG_DS = 2'b11;

endpackage

// ==== verilog/ea_decode.sv ====
`timescale 1ns/1ps

module ea_decode (
  input  logic [2:0]          rm_i,
  input  logic [1:0]          mod_i,
  output fetch_pkg::reg_sel_t base_o,
  output fetch_pkg::reg_sel_t index_o,
  output fetch_pkg::seg_sel_t seg_o
);

  import fetch_pkg::*;

  logic bp_based; // bp base defaults to stack segment

  always_comb
  begin
    case (rm_i)
      3'b000, 3'b001, 3'b111: base_o = REG_BX;
      3'b010, 3'b011:         base_o = REG_BP;
      3'b100, 3'b101:         base_o = REG_NONE;  // [si] / [di]
      default:                base_o = (mod_i == 2'b00) ? REG_NONE : REG_BP; // direct
    endcase
  end

  // si on even rm, di on odd, none for 110 and 111
  assign index_o = (rm_i[2:1] == 2'b11) ? REG_NONE
                 : rm_i[0]              ? REG_DI : REG_SI;

  assign bp_based = (rm_i[2:1] == 2'b01)
                  | (rm_i == 3'b110 && mod_i != 2'b00);
  assign seg_o    = bp_based ? SEG_SS : SEG_DS;

endmodule

// ==== verilog/opcode_deco.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module opcode_deco (
  input  logic [`BYTE_W-1:0]    opcode_i,
  input  logic [`BYTE_W-1:0]    modrm_i,
  output fetch_pkg::seq_entry_t seq_o,
  output logic                  need_modrm_o,
  output logic                  need_off_o,
  output logic                  need_imm_o,
  output logic                  off_size_o,
  output logic                  imm_size_o,
  output fetch_pkg::reg_sel_t   src_o,
  output fetch_pkg::reg_sel_t   dst_o,
  output fetch_pkg::reg_sel_t   base_o,
  output fetch_pkg::reg_sel_t   index_o,
  output fetch_pkg::seg_sel_t   seg_o
);

  import fetch_pkg::*;

  logic [1:0] mod;
  logic [2:0] regm, rm;
  logic       d, b;             // direction, byte width
  logic       dm, sm;           // memory on dst / src side
  logic [2:0] srcm, dstm;
  logic       direct;           // [disp16] form
  logic       need_off_mod, off_size_mod;

  ea_decode u_ea (
    .rm_i    (rm),
    .mod_i   (mod),
    .base_o  (base_o),
    .index_o (index_o),
    .seg_o   (seg_o)
  );

  assign mod  = modrm_i[7:6];
  assign regm = modrm_i[5:3];
  assign rm   = modrm_i[2:0];
  assign d    = opcode_i[1];
  assign b    = ~opcode_i[0];
  assign dm   = ~d & (mod != 2'b11);
  assign sm   =  d & (mod != 2'b11);
  assign srcm = d ? rm : regm;
  assign dstm = d ? regm : rm;

  assign direct       = (base_o == REG_NONE) && (index_o == REG_NONE);
  assign need_off_mod = direct | ^mod;    // mod 01 / 10 carry a disp
  assign off_size_mod = direct | mod[1];  // disp16 for mod 10 and direct

  always_comb
  begin
    seq_o        = SEQ_NOP;
    need_modrm_o = 1'b0;
    need_off_o   = 1'b0;
    need_imm_o   = 1'b0;
    off_size_o   = 1'b0;
    imm_size_o   = 1'b0;
    src_o        = REG_AX;
    dst_o        = REG_AX;
    casez (opcode_i)
      8'b1000_10??: // mov r/m <-> r
      begin
        need_modrm_o = 1'b1;
        off_size_o   = off_size_mod;
        if (dm)
        begin
          seq_o      = b ? SEQ_MOVRMB : SEQ_MOVRMW;
          need_off_o = need_off_mod;
          src_o      = {1'b0, srcm};
        end
        else if (sm)
        begin
          seq_o      = b ? SEQ_MOVMRB : SEQ_MOVMRW;
          need_off_o = need_off_mod;
          dst_o      = {1'b0, dstm};
        end
        else
        begin
          seq_o = b ? SEQ_MOVRRB : SEQ_MOVRRW; // reg to reg
          src_o = {1'b0, srcm};
          dst_o = {1'b0, dstm};
        end
      end
      8'b1000_1100: // mov r/m <- sreg
      begin
        need_modrm_o = 1'b1;
        off_size_o   = off_size_mod;
        src_o        = {1'b1, srcm};
        if (dm)
        begin
          seq_o      = SEQ_MOVRMW;
          need_off_o = need_off_mod;
        end
        else
        begin
          seq_o = SEQ_MOVRRW;
          dst_o = {1'b0, dstm};
        end
      end
      8'b1000_1110: // mov sreg <- r/m
      begin
        need_modrm_o = 1'b1;
        off_size_o   = off_size_mod;
        dst_o        = {1'b1, dstm};
        if (sm)
        begin
          seq_o      = SEQ_MOVMRW;
          need_off_o = need_off_mod;
        end
        else
        begin
          seq_o = SEQ_MOVRRW;
          src_o = {1'b0, srcm};
        end
      end
      8'b1001_1100: seq_o = SEQ_PUSHF;
      8'b1010_00??: // accumulator <-> [disp16]
      begin
        if (d)
          seq_o = b ? SEQ_MOVAMB : SEQ_MOVAMW;
        else
          seq_o = b ? SEQ_MOVMAB : SEQ_MOVMAW;
        need_off_o = 1'b1;
        off_size_o = 1'b1;
      end
      8'b1011_????: // mov reg, imm
      begin
        seq_o      = opcode_i[3] ? SEQ_MOVIRW : SEQ_MOVIRB;
        need_imm_o = 1'b1;
        imm_size_o = opcode_i[3];
        dst_o      = {1'b0, opcode_i[2:0]};
      end
      8'b1100_011?: // mov r/m, imm
      begin
        if (mod == 2'b11)
          seq_o = b ? SEQ_MOVIRB : SEQ_MOVIRW;
        else
          seq_o = b ? SEQ_MOVIMB : SEQ_MOVIMW;
        need_modrm_o = 1'b1;
        need_off_o   = need_off_mod;
        off_size_o   = off_size_mod;
        need_imm_o   = 1'b1;
        imm_size_o   = ~b;
        dst_o        = {1'b0, rm};
      end
      8'b1110_10?1: // jmp rel16 (e9) / rel8 (eb)
      begin
        seq_o      = SEQ_JMPI;
        need_imm_o = 1'b1;
        imm_size_o = ~opcode_i[1];
      end
      8'b1110_1010: // jmp far ptr16:16
      begin
        seq_o      = SEQ_LJMPI;
        need_off_o = 1'b1;
        off_size_o = 1'b1;
        need_imm_o = 1'b1;
        imm_size_o = 1'b1;
      end
      8'b1111_0100: seq_o = SEQ_HLT;
      8'b1111_1111: // group 5, only the jmp forms
      begin
        case (regm)
          3'b100:  seq_o = (mod == 2'b11) ? SEQ_JMPR : SEQ_JMPM;
          3'b101:  seq_o = SEQ_LJMPM;
          default: seq_o = SEQ_NOP;
        endcase
        need_modrm_o = 1'b1;
        need_off_o   = need_off_mod;
        off_size_o   = off_size_mod;
        src_o        = {1'b0, rm};
      end
      default: seq_o = SEQ_NOP; // anything else is skipped
    endcase
  end

  // fetch_ctrl relies on this to visit the offset phase
  always_comb
  begin
    if (opcode_i[7:2] == 6'b1010_00 || opcode_i == 8'hEA)
      a_need_off: assert (need_off_o)
        else $error("no displacement fetch for opcode %h", opcode_i);
  end

endmodule

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`WORD_W-1:0]   cs_i,
  input  logic [`WORD_W-1:0]   ip_i,
  input  logic                 need_modrm_i,
  input  logic                 need_off_i,
  input  logic                 need_imm_i,
  input  logic                 off_size_i,   // 1 -> word displacement
  input  logic                 imm_size_i,   // 1 -> word immediate
  output fetch_pkg::fetch_state_t state_o,
  output logic [`ADDR_W-1:0]   pc_o,
  output logic                 bytefetch_o,
  output logic [`WORD_W-1:0]   ip_inc_o,
  output logic                 exec_o
);

  import fetch_pkg::*;

  localparam logic [`WORD_W-1:0] INC_NONE = '0;
  localparam logic [`WORD_W-1:0] INC_BYTE = `WORD_W'(1);
  localparam logic [`WORD_W-1:0] INC_WORD = `WORD_W'(2);

  fetch_state_t             state_q, state_d;
  logic                     word_fetch;       // current phase reads two bytes
  logic [`ADDR_W-1:0]       seg_base, ip_ext;

  // next phase, skipping fields the opcode does not need
  always_comb
  begin
    case (state_q)
      OPCOD:   state_d = need_modrm_i ? MODRM
                       : need_off_i   ? OFFSE
                       : need_imm_i   ? IMMED : EXECU;
      MODRM:   state_d = need_off_i ? OFFSE
                       : need_imm_i ? IMMED : EXECU;
      OFFSE:   state_d = need_imm_i ? IMMED : EXECU;
      IMMED:   state_d = EXECU;
      default: state_d = OPCOD; // execute lasts one cycle
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= OPCOD; // first cycle fetches an opcode
    else
      state_q <= state_d;
  end

  assign word_fetch = (state_q == OFFSE && off_size_i)
                    | (state_q == IMMED && imm_size_i);

  assign exec_o      = (state_q == EXECU);
  assign bytefetch_o = ~word_fetch;    // high in execute too
  assign ip_inc_o    = exec_o     ? INC_NONE
                     : word_fetch ? INC_WORD : INC_BYTE;

  // cs * 16 + ip
  assign seg_base = {{(`ADDR_W-`WORD_W){1'b0}}, cs_i} << `SEG_SHIFT;
  assign ip_ext   = {{(`ADDR_W-`WORD_W){1'b0}}, ip_i};
  assign pc_o     = seg_base + ip_ext;

  assign state_o = state_q;

  a_state_legal: assert property (@(posedge clk) disable iff (rst)
    state_q inside {OPCOD, MODRM, OFFSE, IMMED, EXECU})
    else $error("fetch state out of range");

  a_exec_to_opcod: assert property (@(posedge clk) disable iff (rst)
    state_q == EXECU |=> state_q == OPCOD)
    else $error("execute not followed by opcode fetch");

endmodule

// ==== verilog/instr_latch.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module instr_latch (
  input  logic                    clk,
  input  logic                    rst,
  input  fetch_pkg::fetch_state_t state_i,
  input  logic [`WORD_W-1:0]      data_i,    // word at pc, low byte first
  output logic [`BYTE_W-1:0]      opcode_o,
  output logic [`BYTE_W-1:0]      modrm_o,
  output logic [`WORD_W-1:0]      off_o,
  output logic [`WORD_W-1:0]      imm_o
);

  import fetch_pkg::*;

  localparam logic [`BYTE_W-1:0] OP_NOP = 8'h90; // xchg ax,ax

  logic [`BYTE_W-1:0] opcode_l, modrm_l;
  logic [`WORD_W-1:0] off_l, imm_l;

  always_ff @(posedge clk)
  begin
    if (rst)
      opcode_l <= OP_NOP; // decode sees a harmless opcode out of reset
    else if (state_i == OPCOD)
      opcode_l <= data_i[`BYTE_W-1:0];
  end

  // field registers, loaded in the phase that reads them
  always_ff @(posedge clk)
  begin
    case (state_i)
      OPCOD:   off_l   <= '0;     // no displacement unless fetched
      MODRM:   modrm_l <= data_i[`BYTE_W-1:0];
      OFFSE:   off_l   <= data_i; // whole word, byte or not
      IMMED:   imm_l   <= data_i;
      default: ;                  // execute holds everything
    endcase
  end

  // live byte while it is on the bus, so decode settles this cycle
  assign opcode_o = (state_i == OPCOD) ? data_i[`BYTE_W-1:0] : opcode_l;
  assign modrm_o  = (state_i == MODRM) ? data_i[`BYTE_W-1:0] : modrm_l;
  assign off_o    = off_l;
  assign imm_o    = imm_l;

  // handover from bypass to register must not glitch the opcode
  a_opcode_stable: assert property (@(posedge clk) disable iff (rst)
    state_i != OPCOD |-> $stable(opcode_o))
    else $error("opcode changed inside an instruction");

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`WORD_W-1:0]    cs_i,
  input  logic [`WORD_W-1:0]    ip_i,
  input  logic [`WORD_W-1:0]    data_i,
  output logic [`ADDR_W-1:0]    pc_o,
  output logic                  bytefetch_o,
  output logic [`WORD_W-1:0]    ip_inc_o,
  output logic                  exec_o,
  output fetch_pkg::seq_entry_t seq_o,
  output fetch_pkg::reg_sel_t   src_o,
  output fetch_pkg::reg_sel_t   dst_o,
  output fetch_pkg::reg_sel_t   base_o,
  output fetch_pkg::reg_sel_t   index_o,
  output fetch_pkg::seg_sel_t   seg_o,
  output logic [`WORD_W-1:0]    off_o,
  output logic [`WORD_W-1:0]    imm_o
);

  import fetch_pkg::*;

  fetch_state_t       state;
  logic [`BYTE_W-1:0] opcode, modrm;
  logic               need_modrm, need_off, need_imm;
  logic               off_size, imm_size;

  fetch_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .cs_i         (cs_i),
    .ip_i         (ip_i),
    .need_modrm_i (need_modrm),
    .need_off_i   (need_off),
    .need_imm_i   (need_imm),
    .off_size_i   (off_size),
    .imm_size_i   (imm_size),
    .state_o      (state),
    .pc_o         (pc_o),
    .bytefetch_o  (bytefetch_o),
    .ip_inc_o     (ip_inc_o),
    .exec_o       (exec_o)
  );

  instr_latch u_latch (
    .clk      (clk),
    .rst      (rst),
    .state_i  (state),
    .data_i   (data_i),
    .opcode_o (opcode),
    .modrm_o  (modrm),
    .off_o    (off_o),
    .imm_o    (imm_o)
  );

  opcode_deco u_deco (
    .opcode_i     (opcode),
    .modrm_i      (modrm),
    .seq_o        (seq_o),
    .need_modrm_o (need_modrm),
    .need_off_o   (need_off),
    .need_imm_o   (need_imm),
    .off_size_o   (off_size),
    .imm_size_o   (imm_size),
    .src_o        (src_o),
    .dst_o        (dst_o),
    .base_o       (base_o),
    .index_o      (index_o),
    .seg_o        (seg_o)
  );

endmodule

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ps

`include "fetch_defines.svh"

module fetch_tb;
  import fetch_pkg::*;

  logic clk, rst;
  logic [`WORD_W-1:0] cs, ip, data;
  logic [`ADDR_W-1:0] pc_o;
  logic bytefetch_o, exec_o;
  logic [`WORD_W-1:0] ip_inc_o, off_o, imm_o;
  seq_entry_t seq_o;
  reg_sel_t src_o, dst_o, base_o, index_o;
  seg_sel_t seg_o;

  logic [7:0] mem [0:(1<<`ADDR_W)-1]; // byte wide instruction memory
  integer seed = 94232;
  integer r;
  // expected values from the reference function and the driver
  seq_entry_t e_seq;
  logic e_nm, e_nof, e_nimm, e_osz, e_isz, e_regs, e_ea;
  reg_sel_t e_src, e_dst, e_base, e_idx;
  seg_sel_t e_seg;
  logic exp_valid, exp_exec, exp_bf, exec_seen;
  logic [`ADDR_W-1:0] exp_pc;
  logic [`WORD_W-1:0] exp_inc, exp_off, exp_imm, inc_seen;

  fetch_top DUT (
    .clk(clk), .rst(rst), .cs_i(cs), .ip_i(ip), .data_i(data),
    .pc_o(pc_o), .bytefetch_o(bytefetch_o), .ip_inc_o(ip_inc_o), .exec_o(exec_o),
    .seq_o(seq_o), .src_o(src_o), .dst_o(dst_o), .base_o(base_o),
    .index_o(index_o), .seg_o(seg_o), .off_o(off_o), .imm_o(imm_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // reference decoder for the data-movement and jump opcodes
  function automatic void ref_decode(input logic [7:0] op, input logic [7:0] m);
    logic [1:0] md;
    logic [2:0] rg, rm;
    logic mm, direct;
    md = m[7:6];
    rg = m[5:3];
    rm = m[2:0];
    mm = (md != 2'b11);                 // memory operand
    direct = (md == 2'b00 && rm == 3'b110);
    e_seq = SEQ_NOP;
    e_nm = 0;
    e_nof = 0;
    e_nimm = 0;
    e_osz = 0;
    e_isz = 0;
    e_src = 4'h0;
    e_dst = 4'h0;
    e_regs = 0;
    if (op[7:2] == 6'b100010)
    begin
      e_nm = 1;
      e_regs = 1;
      if (!mm)
      begin
        e_seq = op[0] ? SEQ_MOVRRW : SEQ_MOVRRB;
        e_src = op[1] ? {1'b0, rm} : {1'b0, rg}; // d bit picks the source
        e_dst = op[1] ? {1'b0, rg} : {1'b0, rm};
      end
      else if (op[1])
      begin
        e_seq = op[0] ? SEQ_MOVMRW : SEQ_MOVMRB;
        e_dst = {1'b0, rg};
      end
      else
      begin
        e_seq = op[0] ? SEQ_MOVRMW : SEQ_MOVRMB;
        e_src = {1'b0, rg};
      end
    end
    else if (op == 8'h8C)
    begin
      e_nm = 1;
      e_regs = 1;
      e_src = {1'b1, rg}; // sreg on the source side
      e_seq = mm ? SEQ_MOVRMW : SEQ_MOVRRW;
      if (!mm) e_dst = {1'b0, rm};
    end
    else if (op == 8'h8E)
    begin
      e_nm = 1;
      e_regs = 1;
      e_dst = {1'b1, rg};
      e_seq = mm ? SEQ_MOVMRW : SEQ_MOVRRW;
      if (!mm) e_src = {1'b0, rm};
    end
    else if (op == 8'h9C) e_seq = SEQ_PUSHF;
    else if (op[7:2] == 6'b101000)
    begin
      e_seq = op[1] ? (op[0] ? SEQ_MOVAMW : SEQ_MOVAMB) : (op[0] ? SEQ_MOVMAW : SEQ_MOVMAB);
      e_nof = 1;
      e_osz = 1;                        // always disp16
    end
    else if (op[7:4] == 4'hB)
    begin
      e_seq = op[3] ? SEQ_MOVIRW : SEQ_MOVIRB;
      e_nimm = 1;
      e_isz = op[3];
      e_dst = {1'b0, op[2:0]};
      e_regs = 1;
    end
    else if (op[7:1] == 7'b1100011)
    begin
      e_nm = 1;
      e_nimm = 1;
      e_isz = op[0];
      e_dst = {1'b0, rm};
      e_regs = 1;
      e_seq = mm ? (op[0] ? SEQ_MOVIMW : SEQ_MOVIMB) : (op[0] ? SEQ_MOVIRW : SEQ_MOVIRB);
    end
    else if (op == 8'hE9 || op == 8'hEB)
    begin
      e_seq = SEQ_JMPI;
      e_nimm = 1;
      e_isz = ~op[1];
    end
    else if (op == 8'hEA)
    begin
      e_seq = SEQ_LJMPI;
      e_nof = 1;
      e_osz = 1;
      e_nimm = 1;
      e_isz = 1;
    end
    else if (op == 8'hF4) e_seq = SEQ_HLT;
    else if (op == 8'hFF)
    begin
      e_nm = 1;
      if (rg == 3'd4) e_seq = mm ? SEQ_JMPM : SEQ_JMPR;
      else if (rg == 3'd5) e_seq = SEQ_LJMPM;
    end
    if (e_nm && mm)
    begin
      e_nof = (md != 2'b00) || direct;
      e_osz = (md == 2'b10) || direct;
    end
    e_ea = e_nm && mm;
    // 16-bit addressing table with 3 = bx, 5 = bp, 6 = si, 7 = di and c = none
    e_base = (rm == 3'd0 || rm == 3'd1 || rm == 3'd7) ? 4'h3
           : (rm == 3'd2 || rm == 3'd3) ? 4'h5
           : (rm == 3'd6 && !direct) ? 4'h5 : 4'hC;
    e_idx  = (rm == 3'd6 || rm == 3'd7) ? 4'hC : (rm[0] ? 4'h7 : 4'h6);
    e_seg  = (rm == 3'd2 || rm == 3'd3 || (rm == 3'd6 && !direct)) ? 2'b10 : 2'b11;
  endfunction

  function automatic logic [`ADDR_W-1:0] phys(input logic [15:0] off);
    return ({4'h0, cs} << 4) + {4'h0, off};
  endfunction

  // outputs settle after the falling edge and are compared on the rising edge
  always @(posedge clk)
  begin
    if (exp_valid)
    begin
      check("pc_o", pc_o, exp_pc);
      check("exec_o", exec_o, exp_exec);
      check("ip_inc_o", ip_inc_o, exp_inc);
      check("bytefetch_o", bytefetch_o, exp_bf);
      if (exp_exec)
      begin
        check("seq_o", seq_o, e_seq);
        check("off_o", off_o, exp_off);
        if (e_nimm) check("imm_o", imm_o, exp_imm);
        if (e_regs) check("src_o", src_o, e_src);
        if (e_regs) check("dst_o", dst_o, e_dst);
        if (e_ea) check("base_o", base_o, e_base);
        if (e_ea) check("index_o", index_o, e_idx);
        if (e_ea) check("seg_o", seg_o, e_seg);
      end
      inc_seen = ip_inc_o;
      exec_seen = exec_o;
    end
  end

  // place one instruction at ip and step it through fetch and execute
  task automatic run(input logic [7:0] op, input logic [7:0] m);
    logic [7:0] q[$];
    logic wf[4];
    int kind[4];
    int nf;
    logic [`WORD_W-1:0] fld;
    ref_decode(op, m);
    fld = $random(seed);
    q.push_back(op);
    nf = 1;
    wf[0] = 0;
    kind[0] = 0;
    if (e_nm)
    begin
      q.push_back(m);
      wf[nf] = 0;
      kind[nf] = 1;
      nf++;
    end
    if (e_nof)
    begin
      q.push_back(fld[7:0]);
      if (e_osz) q.push_back(fld[15:8]);
      wf[nf] = e_osz;
      kind[nf] = 2;
      nf++;
    end
    fld = $random(seed);
    if (e_nimm)
    begin
      q.push_back(fld[7:0]);
      if (e_isz) q.push_back(fld[15:8]);
      wf[nf] = e_isz;
      kind[nf] = 3;
      nf++;
    end
    foreach (q[k]) mem[phys(ip + 16'(k))] = q[k];
    exp_off = '0;
    for (int cyc = 0; cyc < 8; cyc++)
    begin
      exp_pc = phys(ip);
      data = {mem[exp_pc + `ADDR_W'(1)], mem[exp_pc]};  // little endian word at pc
      exp_exec = (cyc >= nf);
      exp_inc = exp_exec ? 16'd0 : (wf[cyc] ? 16'd2 : 16'd1);
      exp_bf = exp_exec ? 1'b1 : ~wf[cyc];
      if (!exp_exec && kind[cyc] == 2) exp_off = data;
      if (!exp_exec && kind[cyc] == 3) exp_imm = data;
      exp_valid = 1;
      exec_seen = 0;
      @(posedge clk);
      @(negedge clk);
      ip = ip + inc_seen;
      if (exec_seen) return;
    end
    $display("no execute cycle within 8 cycles for opcode %h", op);
    $display("test failed");
    $fatal(1, "execute wait timed out");
  endtask

  initial
  begin
    for (int a = 0; a < (1 << `ADDR_W); a++)
      mem[a] = a[7:0] ^ a[15:8] ^ {a[19:16], a[11:8]};
    rst = 1;
    cs = 16'h0100;
    ip = 16'h0000;
    data = '0;
    exp_valid = 0;
    exec_seen = 0;
    inc_seen = '0;
    exp_imm = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 0;
    run(8'hF4, 8'h00);                   // hlt straight out of reset
    for (int i = 0; i < 4; i++)
    begin
      r = $random(seed);
      run(8'h88 + 8'(i), {2'b11, r[5:0]});
    end
    r = $random(seed);
    run(8'h8C, {2'b11, r[5:0]});
    run(8'h8E, {2'b11, r[11:6]});
    for (int md = 0; md < 3; md++)
      for (int rm = 0; rm < 8; rm++)
      begin
        r = $random(seed);
        run(8'h8B, {md[1:0], r[2:0], rm[2:0]});
        run(8'h88, {md[1:0], r[5:3], rm[2:0]});
        run(8'hFF, {md[1:0], 3'd4 + {2'b0, r[6]}, rm[2:0]});
      end
    for (int i = 0; i < 16; i++) run(8'hB0 + 8'(i), 8'h00);
    run(8'hC6, 8'hC3);
    run(8'hC7, 8'h46);
    run(8'hC6, 8'h06);
    run(8'hC7, 8'hD9);
    run(8'hE9, 8'h00);
    run(8'hEB, 8'h00);
    run(8'hEA, 8'h00);
    run(8'h9C, 8'h00);
    for (int i = 0; i < 4; i++) run(8'hA0 + 8'(i), 8'h00);
    run(8'hFF, 8'hE2);
    run(8'hFF, 8'hEA);
    for (int i = 0; i < 10; i++)
    begin
      do r = $random(seed);
      while (r[7:4] == 4'hB || r[7:2] == 6'b100010 || r[7:2] == 6'b101000
             || r[7:0] inside {8'h8C, 8'h8E, 8'h9C, 8'hC6, 8'hC7, 8'hE9,
                               8'hEA, 8'hEB, 8'hF4, 8'hFF});
      run(r[7:0], r[15:8]);            // undefined opcode takes one fetch cycle
    end
    r = $random(seed);
    cs = r[15:0];
    ip = {2'b00, r[29:16]};
    for (int i = 0; i < 300; i++)
    begin
      r = $random(seed);
      if (r[16]) run(r[7:0], r[15:8]);
      else run(r[20] ? 8'h8B : (r[21] ? 8'hC7 : 8'hEA), r[15:8]);
    end
    $display("test passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/ea_decode.sv
verilog/opcode_deco.sv
verilog/fetch_ctrl.sv
verilog/instr_latch.sv
verilog/fetch_top.sv
verif/fetch_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f vlog.f --top-module fetch_tb -Mdir obj_dir

run: compile
	./obj_dir/Vfetch_tb

clean:
	rm -rf obj_dir
